/* verilog/axi_sram_settings.svh */
`ifndef AXI_SRAM_SETTINGS_SVH
`define AXI_SRAM_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// AXI port widths
////////////////////////////////////////////////////////////////////////////

`define AXI_DATA_WIDTH 32
`define AXI_ADDR_WIDTH 32
`define AXI_ID_WIDTH 4
`define AXI_STRB_WIDTH (`AXI_DATA_WIDTH / 8)

////////////////////////////////////////////////////////////////////////////
// On-chip memory
////////////////////////////////////////////////////////////////////////////

// Number of words is 2**SRAM_DEPTH_LOG2
`define SRAM_DEPTH_LOG2 10
// Cycles from address acceptance to data_ok, at least 1
`define SRAM_LATENCY 2

`endif

/* verilog/axi_sram_pkg.sv */
`default_nettype none

`include "axi_sram_settings.svh"

package axi_sram_pkg;

	// Write address channel
	typedef struct packed {
		logic [`AXI_ADDR_WIDTH-1:0] addr;
		logic [3:0] len;
		logic [2:0] size;
		logic [1:0] burst;
		logic [`AXI_ID_WIDTH-1:0] id;
	} axi_aw_t;

	// Read address channel
	typedef struct packed {
		logic [`AXI_ADDR_WIDTH-1:0] addr;
		logic [3:0] len;
		logic [2:0] size;
		logic [1:0] burst;
		logic [`AXI_ID_WIDTH-1:0] id;
	} axi_ar_t;

	typedef struct packed {
		logic [`AXI_DATA_WIDTH-1:0] data;
		logic [`AXI_STRB_WIDTH-1:0] strb;
		logic last;
		logic [`AXI_ID_WIDTH-1:0] id;
	} axi_w_t;

	typedef struct packed {
		logic [`AXI_ID_WIDTH-1:0] id;
		logic [1:0] resp;
	} axi_b_t;

	typedef struct packed {
		logic [`AXI_DATA_WIDTH-1:0] data;
		logic [1:0] resp;
		logic last;
		logic [`AXI_ID_WIDTH-1:0] id;
	} axi_r_t;

	// One command on the SRAM bus
	typedef struct packed {
		logic [`AXI_ADDR_WIDTH-1:0] address;
		logic [`AXI_DATA_WIDTH-1:0] wdata;
		logic [`AXI_STRB_WIDTH-1:0] wmask;
		logic we;
	} sram_req_t;

	typedef enum logic [4:0] {
		ST_IDLE       = 5'b00001,
		ST_WRITE_BUSY = 5'b00010,
		ST_READ_BUSY  = 5'b00100,
		ST_WRITE_BACK = 5'b01000,
		ST_READ_BACK  = 5'b10000
	} bridge_state_e;

endpackage

`default_nettype wire

/* verilog/axi2srambus.sv */
`timescale 1ns/1ns
`default_nettype none

`include "axi_sram_settings.svh"

module axi2srambus
	import axi_sram_pkg::*;
(
	input wire ACLK,
	input wire ARESETn,

	input wire axi_aw_t aw,
	input wire aw_valid,
	output logic aw_ready,

	input wire axi_w_t w,
	input wire w_valid,
	output logic w_ready,

	output axi_b_t b,
	output logic b_valid,
	input wire b_ready,

	input wire axi_ar_t ar,
	input wire ar_valid,
	output logic ar_ready,

	output axi_r_t r,
	output logic r_valid,
	input wire r_ready,

	output logic mem_req,
	output sram_req_t mem_cmd,
	input wire [`AXI_DATA_WIDTH-1:0] mem_rdata,
	input wire mem_addr_ok,
	input wire mem_data_ok,
	output logic mem_data_ok_resp
);

	bridge_state_e state;
	bridge_state_e state_next;

	logic [`AXI_ID_WIDTH-1:0] txn_id;
	logic [`AXI_ADDR_WIDTH-1:0] wr_addr;
	logic [`AXI_DATA_WIDTH-1:0] r_data;

	logic aw_hs;
	logic ar_hs;
	logic w_last_hs;
	logic b_hs;
	logic r_hs;

	assign aw_hs = aw_valid && aw_ready;
	assign ar_hs = ar_valid && ar_ready;
	assign w_last_hs = w_valid && w_ready && w.last;
	assign b_hs = b_valid && b_ready;
	assign r_hs = r_valid && r_ready;

	// Write has priority over read in idle
	assign aw_ready = (state == ST_IDLE);
	assign ar_ready = (state == ST_IDLE) && !aw_valid;

	// Beats from another ID are held off; nothing more after WLAST
	assign w_ready = (state == ST_WRITE_BUSY) && !mem_req && (w.id == txn_id);

	assign mem_data_ok_resp = (state == ST_WRITE_BACK) || (state == ST_READ_BACK);

	assign b = '{id: b_valid ? txn_id : '0, resp: 2'b00};
	assign r = '{data: r_data, resp: 2'b00, last: r_valid, id: r_valid ? txn_id : '0};

	////////////////////////////////////////////////////////////////////////////
	// State machine
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			state <= ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE: begin
				if (aw_valid) begin
					state_next = ST_WRITE_BUSY;
				end else if (ar_valid) begin
					state_next = ST_READ_BUSY;
				end
			end
			ST_WRITE_BUSY: begin
				if (mem_req && mem_addr_ok) begin
					state_next = ST_WRITE_BACK;
				end
			end
			ST_READ_BUSY: begin
				if (mem_req && mem_addr_ok) begin
					state_next = ST_READ_BACK;
				end
			end
			ST_WRITE_BACK: begin
				if (b_hs) begin
					state_next = ST_IDLE;
				end
			end
			ST_READ_BACK: begin
				if (r_hs) begin
					state_next = ST_IDLE;
				end
			end
			default: begin
				state_next = ST_IDLE;
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// SRAM bus request
	////////////////////////////////////////////////////////////////////////////

	// Request stays up until the memory takes it
	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			mem_req <= 1'b0;
		end else if (ar_hs || w_last_hs) begin
			mem_req <= 1'b1;
		end else if (mem_addr_ok) begin
			mem_req <= 1'b0;
		end
	end

	always_ff @(posedge ACLK) begin
		if (aw_hs) begin
			txn_id <= aw.id;
			wr_addr <= aw.addr;
		end else if (ar_hs) begin
			txn_id <= ar.id;
		end
		// Only the last beat is written, at the AW address
		if (ar_hs) begin
			mem_cmd <= '{address: ar.addr, wdata: '0, wmask: '0, we: 1'b0};
		end else if (w_last_hs) begin
			mem_cmd <= '{address: wr_addr, wdata: w.data, wmask: w.strb, we: 1'b1};
		end
		if (state == ST_READ_BACK && mem_data_ok) begin
			r_data <= mem_rdata;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Responses
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			b_valid <= 1'b0;
			r_valid <= 1'b0;
		end else begin
			if (state == ST_WRITE_BACK && mem_data_ok) begin
				b_valid <= 1'b1;
			end else if (b_hs) begin
				b_valid <= 1'b0;
			end
			if (state == ST_READ_BACK && mem_data_ok) begin
				r_valid <= 1'b1;
			end else if (r_hs) begin
				r_valid <= 1'b0;
			end
		end
	end

	// Command held while the memory is busy
	assert property (@(posedge ACLK) disable iff (!ARESETn)
		mem_req && !mem_addr_ok |=> mem_req && $stable(mem_cmd));

	assert property (@(posedge ACLK) disable iff (!ARESETn)
		r_valid && !r_ready |=> r_valid && $stable(r));

	assert property (@(posedge ACLK) disable iff (!ARESETn) $onehot0(state));

endmodule

`default_nettype wire

/* verilog/sram_port.sv */
`timescale 1ns/1ns
`default_nettype none

`include "axi_sram_settings.svh"

module sram_port
	import axi_sram_pkg::*;
#(
	parameter int DEPTH_LOG2 = `SRAM_DEPTH_LOG2,
	parameter int LATENCY = `SRAM_LATENCY
) (
	input wire ACLK,
	input wire ARESETn,
	input wire mem_req,
	input wire sram_req_t mem_cmd,
	input wire mem_data_ok_resp,
	output logic mem_addr_ok,
	output logic mem_data_ok,
	output logic [`AXI_DATA_WIDTH-1:0] mem_rdata
);

	localparam int OFFSET = $clog2(`AXI_STRB_WIDTH);
	localparam int CNT_W = $clog2(LATENCY + 1);

	logic [`AXI_DATA_WIDTH-1:0] mem [0:(2**DEPTH_LOG2)-1];
	logic [DEPTH_LOG2-1:0] idx;
	logic accept;
	logic pending;
	logic [CNT_W-1:0] count;

	// Word index, byte offset dropped
	assign idx = mem_cmd.address[OFFSET +: DEPTH_LOG2];

	assign mem_addr_ok = !pending;
	assign accept = mem_req && mem_addr_ok;
	assign mem_data_ok = pending && (count == '0) && mem_data_ok_resp;

	always_ff @(posedge ACLK) begin
		if (accept) begin
			if (mem_cmd.we) begin
				for (int i = 0; i < `AXI_STRB_WIDTH; i++) begin
					if (mem_cmd.wmask[i]) begin
						mem[idx][8*i +: 8] <= mem_cmd.wdata[8*i +: 8];
					end
				end
			end else begin
				mem_rdata <= mem[idx];
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Latency counter
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			pending <= 1'b0;
			count <= '0;
		end else if (accept) begin
			pending <= 1'b1;
			count <= CNT_W'(LATENCY - 1);
		end else if (pending) begin
			if (count != '0) begin
				count <= count - 1'b1;
			end else if (mem_data_ok_resp) begin
				// Held here until the bridge can take the result
				pending <= 1'b0;
			end
		end
	end

	// data_ok retires the pending request
	assert property (@(posedge ACLK) disable iff (!ARESETn)
		mem_data_ok |-> pending ##1 !pending);

	// Result due exactly LATENCY cycles after acceptance
	assert property (@(posedge ACLK) disable iff (!ARESETn)
		accept |-> ##LATENCY (!mem_addr_ok && (mem_data_ok || !mem_data_ok_resp)));

endmodule

`default_nettype wire

/* verilog/axi_sram_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "axi_sram_settings.svh"

module axi_sram_top
	import axi_sram_pkg::*;
(
	input wire ACLK,
	input wire ARESETn,
	input wire axi_aw_t aw,
	input wire aw_valid,
	output wire aw_ready,
	input wire axi_w_t w,
	input wire w_valid,
	output wire w_ready,
	output wire axi_b_t b,
	output wire b_valid,
	input wire b_ready,
	input wire axi_ar_t ar,
	input wire ar_valid,
	output wire ar_ready,
	output wire axi_r_t r,
	output wire r_valid,
	input wire r_ready
);

	wire mem_req;
	wire sram_req_t mem_cmd;
	wire [`AXI_DATA_WIDTH-1:0] mem_rdata;
	wire mem_addr_ok;
	wire mem_data_ok;
	wire mem_data_ok_resp;

	axi2srambus u_bridge (
		.ACLK(ACLK),
		.ARESETn(ARESETn),
		.aw(aw),
		.aw_valid(aw_valid),
		.aw_ready(aw_ready),
		.w(w),
		.w_valid(w_valid),
		.w_ready(w_ready),
		.b(b),
		.b_valid(b_valid),
		.b_ready(b_ready),
		.ar(ar),
		.ar_valid(ar_valid),
		.ar_ready(ar_ready),
		.r(r),
		.r_valid(r_valid),
		.r_ready(r_ready),
		.mem_req(mem_req),
		.mem_cmd(mem_cmd),
		.mem_rdata(mem_rdata),
		.mem_addr_ok(mem_addr_ok),
		.mem_data_ok(mem_data_ok),
		.mem_data_ok_resp(mem_data_ok_resp)
	);

	sram_port #(
		.DEPTH_LOG2(`SRAM_DEPTH_LOG2),
		.LATENCY(`SRAM_LATENCY)
	) u_sram (
		.ACLK(ACLK),
		.ARESETn(ARESETn),
		.mem_req(mem_req),
		.mem_cmd(mem_cmd),
		.mem_data_ok_resp(mem_data_ok_resp),
		.mem_addr_ok(mem_addr_ok),
		.mem_data_ok(mem_data_ok),
		.mem_rdata(mem_rdata)
	);

endmodule

`default_nettype wire

/* testbench/axi_sram_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "axi_sram_settings.svh"

module axi_sram_tb
	import axi_sram_pkg::*;
();

	localparam int LAT = `SRAM_LATENCY;
	localparam int DEPTH = `SRAM_DEPTH_LOG2;
	localparam int OFFSET = $clog2(`AXI_STRB_WIDTH);
	localparam int TIMEOUT = 100;

	logic ACLK;
	logic ARESETn;
	axi_aw_t aw;
	logic aw_valid;
	logic aw_ready;
	axi_w_t w;
	logic w_valid;
	logic w_ready;
	axi_b_t b;
	logic b_valid;
	logic b_ready;
	axi_ar_t ar;
	logic ar_valid;
	logic ar_ready;
	axi_r_t r;
	logic r_valid;
	logic r_ready;

	// Shadow of the memory contents, built from the write rules
	logic [`AXI_DATA_WIDTH-1:0] shadow [0:(2**DEPTH)-1];
	logic [`AXI_ADDR_WIDTH-1:0] addrs [0:7];
	logic [`AXI_DATA_WIDTH-1:0] exp_rdata;
	logic [`AXI_ID_WIDTH-1:0] exp_rid;
	logic [`AXI_ID_WIDTH-1:0] exp_bid;
	logic [`AXI_ID_WIDTH-1:0] cur_awid;
	int errors;
	int tests;
	int test_base;

	axi_sram_top uut (
		.ACLK(ACLK),
		.ARESETn(ARESETn),
		.aw(aw),
		.aw_valid(aw_valid),
		.aw_ready(aw_ready),
		.w(w),
		.w_valid(w_valid),
		.w_ready(w_ready),
		.b(b),
		.b_valid(b_valid),
		.b_ready(b_ready),
		.ar(ar),
		.ar_valid(ar_valid),
		.ar_ready(ar_ready),
		.r(r),
		.r_valid(r_valid),
		.r_ready(r_ready)
	);

	initial begin
		ACLK = 1'b0;
		forever #50 ACLK = ~ACLK;
	end

	task automatic note_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		errors++;
		$display("mismatch %s: got 0x%h, expected 0x%h", name, got, want);
	endtask

	task automatic note_failure(input string what);
		errors++;
		$display("%s", what);
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (errors == test_base) begin
			$display("test %0d %s: ok", tests, name);
		end else begin
			$display("test %0d %s: %0d errors", tests, name, errors - test_base);
		end
		test_base = errors;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	assert property (@(posedge ACLK)
		$rose(ARESETn) |-> aw_ready && ar_ready && !w_ready && !b_valid && !r_valid)
		else note_failure("outputs were not at their reset values after reset");

	assert property (@(posedge ACLK) disable iff (!ARESETn)
		r_valid |-> r.data == exp_rdata)
		else note_mismatch("r.data", $sampled(r.data), $sampled(exp_rdata));

	assert property (@(posedge ACLK) disable iff (!ARESETn)
		r_valid |-> r.id == exp_rid)
		else note_mismatch("r.id", $sampled(r.id), $sampled(exp_rid));

	assert property (@(posedge ACLK) disable iff (!ARESETn)
		r_valid |-> r.resp == 2'b00)
		else note_mismatch("r.resp", $sampled(r.resp), 0);

	assert property (@(posedge ACLK) disable iff (!ARESETn) r_valid |-> r.last)
		else note_failure("r.last was low on a read beat");

	assert property (@(posedge ACLK) disable iff (!ARESETn)
		b_valid |-> b.id == exp_bid)
		else note_mismatch("b.id", $sampled(b.id), $sampled(exp_bid));

	assert property (@(posedge ACLK) disable iff (!ARESETn)
		b_valid |-> b.resp == 2'b00)
		else note_mismatch("b.resp", $sampled(b.resp), 0);

	// IDs read zero when idle
	assert property (@(posedge ACLK) disable iff (!ARESETn) !r_valid |-> r.id == '0)
		else note_mismatch("r.id", $sampled(r.id), 0);

	assert property (@(posedge ACLK) disable iff (!ARESETn) !b_valid |-> b.id == '0)
		else note_mismatch("b.id", $sampled(b.id), 0);

	assert property (@(posedge ACLK) disable iff (!ARESETn)
		ar_valid && ar_ready |-> ##(LAT + 2) $rose(r_valid))
		else note_failure("r_valid did not rise at the expected cycle after AR");

	assert property (@(posedge ACLK) disable iff (!ARESETn)
		w_valid && w_ready && w.last |-> ##(LAT + 2) $rose(b_valid))
		else note_failure("b_valid did not rise at the expected cycle after WLAST");

	assert property (@(posedge ACLK) disable iff (!ARESETn)
		r_valid && !r_ready |=> r_valid && $stable(r))
		else note_failure("r changed while waiting for r_ready");

	assert property (@(posedge ACLK) disable iff (!ARESETn)
		b_valid && !b_ready |=> b_valid && $stable(b))
		else note_failure("b changed while waiting for b_ready");

	assert property (@(posedge ACLK) disable iff (!ARESETn)
		r_valid || b_valid |-> !aw_ready && !ar_ready)
		else note_failure("an address was accepted before the response handshake");

	assert property (@(posedge ACLK) disable iff (!ARESETn) aw_valid |-> !ar_ready)
		else note_failure("read address accepted while a write address was waiting");

	assert property (@(posedge ACLK) disable iff (!ARESETn)
		w_valid && w.id != cur_awid |-> !w_ready)
		else note_failure("write beat with a foreign WID was accepted");

	////////////////////////////////////////////////////////////////////////////
	// Bus tasks, all entered and left just after a falling edge
	////////////////////////////////////////////////////////////////////////////

	task automatic issue_write_addr(input logic [31:0] addr, input logic [3:0] id,
		input logic [3:0] len);
		int n;
		aw = '{addr: addr, len: len, size: 3'd2, burst: 2'b01, id: id};
		aw_valid = 1'b1;
		cur_awid = id;
		exp_bid = id;
		n = 0;
		@(posedge ACLK);
		while (!aw_ready && n < TIMEOUT) begin
			@(posedge ACLK);
			n++;
		end
		if (!aw_ready) begin
			note_failure("timeout waiting for aw_ready");
		end
		@(negedge ACLK);
		aw_valid = 1'b0;
	endtask

	task automatic push_w_beat(input logic [31:0] data, input logic [3:0] strb,
		input logic last, input logic [3:0] id);
		int n;
		w = '{data: data, strb: strb, last: last, id: id};
		w_valid = 1'b1;
		n = 0;
		@(posedge ACLK);
		while (!w_ready && n < TIMEOUT) begin
			@(posedge ACLK);
			n++;
		end
		if (!w_ready) begin
			note_failure("timeout waiting for w_ready");
		end
		@(negedge ACLK);
		w_valid = 1'b0;
	endtask

	// Beat from another ID, which must be held off
	task automatic present_foreign_wid(input logic [3:0] id, input int cycles);
		w = '{data: $urandom, strb: 4'hf, last: 1'b1, id: id ^ 4'h1};
		w_valid = 1'b1;
		repeat (cycles) @(negedge ACLK);
	endtask

	task automatic collect_b(input int stall);
		int n;
		n = 0;
		@(posedge ACLK);
		while (!b_valid && n < TIMEOUT) begin
			@(posedge ACLK);
			n++;
		end
		if (!b_valid) begin
			note_failure("timeout waiting for b_valid");
		end else if (!b_ready) begin
			repeat (stall) @(negedge ACLK);
			b_ready = 1'b1;
			@(posedge ACLK);
		end
		@(negedge ACLK);
		b_ready = 1'b1;
	endtask

	task automatic collect_r(input int stall);
		int n;
		n = 0;
		@(posedge ACLK);
		while (!r_valid && n < TIMEOUT) begin
			@(posedge ACLK);
			n++;
		end
		if (!r_valid) begin
			note_failure("timeout waiting for r_valid");
		end else if (!r_ready) begin
			repeat (stall) @(negedge ACLK);
			r_ready = 1'b1;
			@(posedge ACLK);
		end
		@(negedge ACLK);
		r_ready = 1'b1;
	endtask

	task automatic drive_read_addr(input logic [31:0] addr, input logic [3:0] id);
		ar = '{addr: addr, len: 4'd0, size: 3'd2, burst: 2'b01, id: id};
		ar_valid = 1'b1;
		exp_rid = id;
	endtask

	task automatic wait_read_addr();
		int n;
		n = 0;
		@(posedge ACLK);
		while (!ar_ready && n < TIMEOUT) begin
			@(posedge ACLK);
			n++;
		end
		if (!ar_ready) begin
			note_failure("timeout waiting for ar_ready");
		end
		@(negedge ACLK);
		ar_valid = 1'b0;
	endtask

	// Only the last beat lands, merged under its strobes
	task automatic write_word(input logic [31:0] addr, input logic [3:0] id,
		input logic [31:0] data, input logic [3:0] strb, input int beats,
		input int b_stall, input int foreign_cycles);
		if (b_stall > 0) begin
			b_ready = 1'b0;
		end
		issue_write_addr(addr, id, 4'(beats - 1));
		if (foreign_cycles > 0) begin
			present_foreign_wid(id, foreign_cycles);
		end
		for (int i = 0; i < beats - 1; i++) begin
			push_w_beat($urandom, 4'hf, 1'b0, id);
		end
		push_w_beat(data, strb, 1'b1, id);
		for (int i = 0; i < `AXI_STRB_WIDTH; i++) begin
			if (strb[i]) begin
				shadow[addr[OFFSET +: DEPTH]][8*i +: 8] = data[8*i +: 8];
			end
		end
		collect_b(b_stall);
	endtask

	task automatic read_word(input logic [31:0] addr, input logic [3:0] id,
		input int stall);
		exp_rdata = shadow[addr[OFFSET +: DEPTH]];
		if (stall > 0) begin
			r_ready = 1'b0;
		end
		drive_read_addr(addr, id);
		wait_read_addr();
		collect_r(stall);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int k;
		void'($urandom(28));
		ARESETn = 1'b0;
		aw = '0;
		aw_valid = 1'b0;
		w = '0;
		w_valid = 1'b0;
		ar = '0;
		ar_valid = 1'b0;
		b_ready = 1'b1;
		r_ready = 1'b1;
		exp_rdata = '0;
		exp_rid = '0;
		exp_bid = '0;
		cur_awid = '0;
		errors = 0;
		tests = 0;
		test_base = 0;
		repeat (8) @(negedge ACLK);
		ARESETn = 1'b1;
		repeat (2) @(negedge ACLK);
		finish_test("reset values");

		// Full-word fill first so no byte is left unknown
		for (int i = 0; i < 8; i++) begin
			addrs[i] = $urandom & 32'h0000_0ffc;
			write_word(addrs[i], 4'($urandom), $urandom, 4'hf, 1, 0, 0);
		end
		for (int i = 0; i < 8; i++) begin
			write_word(addrs[i], 4'($urandom), $urandom, 4'($urandom), 1, 0, 0);
			read_word(addrs[i], 4'($urandom), 0);
		end
		finish_test("random write and read");

		for (int i = 0; i < 4; i++) begin
			k = $urandom % 8;
			write_word(addrs[k], 4'($urandom), $urandom, 4'($urandom), 1, 0, 0);
			read_word(addrs[k], 4'($urandom), 0);
		end
		finish_test("response latency");

		for (int i = 0; i < 6; i++) begin
			k = $urandom % 8;
			write_word(addrs[k], 4'($urandom), $urandom, 4'($urandom), 1,
				1 + $urandom % 6, 0);
			read_word(addrs[k], 4'($urandom), 1 + $urandom % 6);
		end
		finish_test("response back-pressure");

		// AW and AR raised in the same cycle
		for (int i = 0; i < 3; i++) begin
			k = $urandom % 8;
			drive_read_addr(addrs[k], 4'($urandom));
			write_word(addrs[k], 4'($urandom), $urandom, 4'($urandom), 1, 0,
				1 + $urandom % 4);
			exp_rdata = shadow[addrs[k][OFFSET +: DEPTH]];
			wait_read_addr();
			collect_r(0);
		end
		finish_test("write priority and WID match");

		for (int i = 0; i < 3; i++) begin
			k = $urandom % 8;
			write_word(addrs[k], 4'($urandom), $urandom, 4'($urandom),
				2 + $urandom % 3, 0, 0);
			read_word(addrs[k], 4'($urandom), 0);
		end
		finish_test("multi-beat write");

		repeat (4) @(negedge ACLK);
		$display("tests: %0d, errors: %0d", tests, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+verilog
verilog/axi_sram_pkg.sv
verilog/axi2srambus.sv
verilog/sram_port.sv
verilog/axi_sram_top.sv
testbench/axi_sram_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= axi_sram_tb
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
FAIL_MSG ?= Simulation FAILED

.PHONY: sim clean

# Build and run, then search the log for the fail message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Failure reported in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
